// ==== hdl/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // Major opcodes of the supported subset.
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // Funct3 of the OP and OP-IMM groups.
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Funct7 for register forms.
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // Immediate shifts on RV64 keep a 6-bit shamt.
    localparam logic [5:0] F6_BASE = 6'b000000;
    localparam logic [5:0] F6_SRA  = 6'b010000;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

endpackage

// ==== hdl/pipe_pkg.sv ====
package pipe_pkg;

    import rv_isa_pkg::*;

    localparam int XLEN = 64;

    // Decode to execute.
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [31:0]     inst;
        logic [XLEN-1:0] op1;
        logic [XLEN-1:0] op2;
        alu_op_e         alu_op;
        logic            reg_we;
        logic [4:0]      rd;
        logic            illegal;
    } id_ex_t;

    // Execute to writeback payload, which doubles as the retire trace.
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [31:0]     inst;
        logic [XLEN-1:0] result;
        logic            reg_we;
        logic [4:0]      rd;
        logic            illegal;
    } ex_wb_t;

endpackage

// ==== hdl/reg_file.sv ====
`timescale 1ns/100ps

module reg_file
    import pipe_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic [4:0]      rs1_i,
    input  logic [4:0]      rs2_i,
    output logic [XLEN-1:0] rs1_data_o,
    output logic [XLEN-1:0] rs2_data_o,
    input  logic            we_i,
    input  logic [4:0]      rd_i,
    input  logic [XLEN-1:0] wdata_i
);

    logic [XLEN-1:0] regs [1:31];

    // x0 reads as zero; a same-cycle write is forwarded.
    function automatic logic [XLEN-1:0] read_port(input logic [4:0] addr);
        logic [XLEN-1:0] val;
        if (addr == 5'd0) begin
            val = '0;
        end else if (we_i && (addr == rd_i)) begin
            val = wdata_i;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_i != 5'd0)) begin
            regs[rd_i] <= wdata_i;
        end
    end

    always_comb begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

endmodule

// ==== hdl/decode_unit.sv ====
`timescale 1ns/100ps

module decode_unit
    import rv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic            inst_valid_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [31:0]     inst_i,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    output logic [4:0]      rs1_o,
    output logic [4:0]      rs2_o,
    output logic            use_rs1_o,
    output logic            use_rs2_o,
    output id_ex_t          id_ex_o
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [5:0]      funct6;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic            legal;
    logic            is_op_imm;
    logic            is_op;
    alu_op_e         alu_op;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign funct6 = inst_i[31:26];
    assign imm_i  = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_u  = {{(XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};

    assign is_op_imm = (opcode == OPC_OP_IMM);
    assign is_op     = (opcode == OPC_OP);

    assign rs1_o     = inst_i[19:15];
    assign rs2_o     = inst_i[24:20];
    assign use_rs1_o = inst_valid_i && (is_op_imm || is_op);
    assign use_rs2_o = inst_valid_i && is_op;

    // Base operation for each funct3; SUB and SRA are picked below.
    function automatic alu_op_e base_op(input logic [2:0] f3);
        alu_op_e op;
        case (f3)
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = ALU_SRL;
            F3_OR:      op = ALU_OR;
            F3_AND:     op = ALU_AND;
            default:    op = ALU_ADD;
        endcase
        return op;
    endfunction

    always_comb begin
        legal  = 1'b1;
        alu_op = base_op(funct3);
        if (opcode == OPC_LUI) begin
            alu_op = ALU_PASS_B;
        end else if (is_op_imm) begin
            if (funct3 == F3_SLL) begin
                legal = (funct6 == F6_BASE);
            end else if (funct3 == F3_SRL_SRA) begin
                if (funct6 == F6_SRA) begin
                    alu_op = ALU_SRA;
                end else if (funct6 != F6_BASE) begin
                    legal = 1'b0;
                end
            end
        end else if (is_op) begin
            if (funct7 == F7_ALT) begin
                if (funct3 == F3_ADD_SUB) begin
                    alu_op = ALU_SUB;
                end else if (funct3 == F3_SRL_SRA) begin
                    alu_op = ALU_SRA;
                end else begin
                    legal = 1'b0;
                end
            end else if (funct7 != F7_BASE) begin
                legal = 1'b0;
            end
        end else begin
            legal = 1'b0;
        end
    end

    always_comb begin
        id_ex_o.valid   = inst_valid_i;
        id_ex_o.pc      = pc_i;
        id_ex_o.inst    = inst_i;
        id_ex_o.op1     = (opcode == OPC_LUI) ? '0 : rs1_data_i;
        id_ex_o.op2     = is_op ? rs2_data_i : ((opcode == OPC_LUI) ? imm_u : imm_i);
        id_ex_o.alu_op  = alu_op;
        id_ex_o.reg_we  = inst_valid_i && legal;
        id_ex_o.rd      = inst_i[11:7];
        id_ex_o.illegal = inst_valid_i && !legal;
    end

endmodule

// ==== hdl/hazard_ctrl.sv ====
`timescale 1ns/100ps

module hazard_ctrl
    import pipe_pkg::*;
(
    input  logic       use_rs1_i,
    input  logic       use_rs2_i,
    input  logic [4:0] rs1_i,
    input  logic [4:0] rs2_i,
    input  id_ex_t     id_ex_i,
    input  logic       wb_stall_i,
    output logic       id_ex_stall_o,
    output logic       ex_wb_stall_o,
    output logic       inst_ready_o
);

    logic rs1_hit;
    logic rs2_hit;
    logic hazard;
    logic id_ex_stall;

    // The producer is still in execute and its result is not in the file yet.
    assign rs1_hit = use_rs1_i && (rs1_i != 5'd0) && (rs1_i == id_ex_i.rd);
    assign rs2_hit = use_rs2_i && (rs2_i != 5'd0) && (rs2_i == id_ex_i.rd);
    assign hazard  = id_ex_i.valid && id_ex_i.reg_we && (rs1_hit || rs2_hit);

    assign id_ex_stall   = hazard || wb_stall_i;
    assign id_ex_stall_o = id_ex_stall;
    assign ex_wb_stall_o = wb_stall_i;
    assign inst_ready_o  = !id_ex_stall;

endmodule

// ==== hdl/pipe_reg.sv ====
`timescale 1ns/100ps

module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst_n,
    input  logic stall_i,
    input  logic next_stall_i,
    input  T     data_i,
    output T     data_o
);

    // Stalled with a free successor inserts a bubble; stalled behind
    // a stalled successor keeps its entry.
    always_ff @(posedge clk) begin
        if (rst_n) begin
            data_o <= '0;
        end else if (stall_i && !next_stall_i) begin
            data_o <= '0;
        end else if (!stall_i) begin
            data_o <= data_i;
        end
    end

endmodule

// ==== hdl/alu_exec.sv ====
`timescale 1ns/100ps

module alu_exec
    import rv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  id_ex_t id_ex_i,
    output ex_wb_t ex_wb_o
);

    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [5:0]      shamt;
    logic [XLEN-1:0] result;

    assign op1   = id_ex_i.op1;
    assign op2   = id_ex_i.op2;
    assign shamt = op2[5:0];

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD:    result = op1 + op2;
            ALU_SUB:    result = op1 - op2;
            ALU_SLL:    result = op1 << shamt;
            ALU_SLT:    result = {{(XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            ALU_SLTU:   result = {{(XLEN-1){1'b0}}, op1 < op2};
            ALU_XOR:    result = op1 ^ op2;
            ALU_SRL:    result = op1 >> shamt;
            ALU_SRA:    result = $signed(op1) >>> shamt;
            ALU_OR:     result = op1 | op2;
            ALU_AND:    result = op1 & op2;
            ALU_PASS_B: result = op2;
            default:    result = '0;
        endcase
    end

    // Trace fields ride along with the result.
    always_comb begin
        ex_wb_o.valid   = id_ex_i.valid;
        ex_wb_o.pc      = id_ex_i.pc;
        ex_wb_o.inst    = id_ex_i.inst;
        ex_wb_o.result  = result;
        ex_wb_o.reg_we  = id_ex_i.reg_we;
        ex_wb_o.rd      = id_ex_i.rd;
        ex_wb_o.illegal = id_ex_i.illegal;
    end

endmodule

// ==== hdl/exec_pipe_top.sv ====
`timescale 1ns/100ps

module exec_pipe_top
    import pipe_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            inst_valid_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [31:0]     inst_i,
    output logic            inst_ready_o,
    input  logic            wb_stall_i,
    output logic            retire_valid_o,
    output logic            retire_we_o,
    output logic            retire_illegal_o,
    output logic [XLEN-1:0] retire_pc_o,
    output logic [31:0]     retire_inst_o,
    output logic [4:0]      retire_rd_o,
    output logic [XLEN-1:0] retire_data_o
);

    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic            use_rs1;
    logic            use_rs2;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic            id_ex_stall;
    logic            ex_wb_stall;
    id_ex_t          id_ex_dec;
    id_ex_t          id_ex_d;
    id_ex_t          id_ex_q;
    ex_wb_t          ex_wb_d;
    ex_wb_t          ex_wb_q;

    reg_file i_reg_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (ex_wb_q.valid && ex_wb_q.reg_we && !wb_stall_i),
        .rd_i       (ex_wb_q.rd),
        .wdata_i    (ex_wb_q.result)
    );

    decode_unit i_decode (
        .inst_valid_i (inst_valid_i),
        .pc_i         (pc_i),
        .inst_i       (inst_i),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .rs1_o        (rs1),
        .rs2_o        (rs2),
        .use_rs1_o    (use_rs1),
        .use_rs2_o    (use_rs2),
        .id_ex_o      (id_ex_dec)
    );

    // A held instruction is taken only on the accepting edge.
    always_comb begin
        id_ex_d       = id_ex_dec;
        id_ex_d.valid = id_ex_dec.valid && inst_ready_o;
    end

    hazard_ctrl i_hazard (
        .use_rs1_i     (use_rs1),
        .use_rs2_i     (use_rs2),
        .rs1_i         (rs1),
        .rs2_i         (rs2),
        .id_ex_i       (id_ex_q),
        .wb_stall_i    (wb_stall_i),
        .id_ex_stall_o (id_ex_stall),
        .ex_wb_stall_o (ex_wb_stall),
        .inst_ready_o  (inst_ready_o)
    );

    pipe_reg #(.T(id_ex_t)) i_id_ex (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall_i      (id_ex_stall),
        .next_stall_i (ex_wb_stall),
        .data_i       (id_ex_d),
        .data_o       (id_ex_q)
    );

    alu_exec i_alu (
        .id_ex_i (id_ex_q),
        .ex_wb_o (ex_wb_d)
    );

    pipe_reg #(.T(ex_wb_t)) i_ex_wb (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall_i      (ex_wb_stall),
        .next_stall_i (wb_stall_i),
        .data_i       (ex_wb_d),
        .data_o       (ex_wb_q)
    );

    assign retire_valid_o   = ex_wb_q.valid;
    assign retire_we_o      = ex_wb_q.reg_we;
    assign retire_illegal_o = ex_wb_q.illegal;
    assign retire_pc_o      = ex_wb_q.pc;
    assign retire_inst_o    = ex_wb_q.inst;
    assign retire_rd_o      = ex_wb_q.rd;
    assign retire_data_o    = ex_wb_q.result;

endmodule

// ==== tb/exec_pipe_tb.sv ====
`timescale 1ns/100ps

module exec_pipe_tb;

    // Expected retire trace entry.
    typedef struct packed {
        logic [63:0] pc;
        logic [31:0] inst;
        logic        we;
        logic        illegal;
        logic [4:0]  rd;
        logic [63:0] data;
    } retire_t;

    localparam logic [6:0] LUI_OPC = 7'b0110111;
    localparam logic [6:0] IMM_OPC = 7'b0010011;
    localparam logic [6:0] REG_OPC = 7'b0110011;
    localparam int         LIMIT   = 50;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        inst_valid_i;
    logic [63:0] pc_i;
    logic [31:0] inst_i;
    logic        inst_ready_o;
    logic        wb_stall_i;
    logic        retire_valid_o;
    logic        retire_we_o;
    logic        retire_illegal_o;
    logic [63:0] retire_pc_o;
    logic [31:0] retire_inst_o;
    logic [4:0]  retire_rd_o;
    logic [63:0] retire_data_o;

    logic [63:0] shadow [0:31];
    retire_t     exp_q [$];
    retire_t     held;
    logic        held_valid;
    logic        hold_armed;
    logic [63:0] rng_state;
    logic [63:0] stall_state;
    logic [63:0] next_pc;
    logic        stall_enable;
    int          stall_left;
    int          error_count;
    int          check_count;
    int          retire_count;

    always #20 clk = ~clk;

    exec_pipe_top i_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .inst_valid_i     (inst_valid_i),
        .pc_i             (pc_i),
        .inst_i           (inst_i),
        .inst_ready_o     (inst_ready_o),
        .wb_stall_i       (wb_stall_i),
        .retire_valid_o   (retire_valid_o),
        .retire_we_o      (retire_we_o),
        .retire_illegal_o (retire_illegal_o),
        .retire_pc_o      (retire_pc_o),
        .retire_inst_o    (retire_inst_o),
        .retire_rd_o      (retire_rd_o),
        .retire_data_o    (retire_data_o)
    );

    function automatic logic [63:0] xorshift(input logic [63:0] s);
        logic [63:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    function automatic logic [63:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic alt,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, REG_OPC};
    endfunction

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic alt,
                                          input logic [11:0] imm, input logic [4:0] rd,
                                          input logic [4:0] rs1);
        logic [11:0] field;
        field = imm;
        // Shift immediates put a 6-bit shamt under funct6.
        if (f3 == 3'd1 || f3 == 3'd5) begin
            field = {1'b0, alt, 4'b0, imm[5:0]};
        end
        return {field, rs1, f3, rd, IMM_OPC};
    endfunction

    function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [63:0] a, input logic [63:0] b);
        logic signed [63:0] sa;
        logic [63:0]        r;
        sa = a;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[5:0];
            3'd2: r = {63'd0, $signed(a) < $signed(b)};
            3'd3: r = {63'd0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = sa >>> b[5:0];
                end else begin
                    r = a >> b[5:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string msg);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s: got %h, expected %h",
                     $time, msg, actual, expected);
        end
    endtask

    // Executes one instruction on the shadow registers in program order.
    task automatic model_exec(input logic [31:0] inst, output retire_t exp);
        logic [63:0] a;
        logic [63:0] b;
        logic [2:0]  f3;
        logic        alt;
        logic        legal;
        f3 = inst[14:12];
        a = shadow[inst[19:15]];
        b = {{52{inst[31]}}, inst[31:20]};
        alt = 1'b0;
        legal = 1'b1;
        exp.data = '0;
        if (inst[6:0] == LUI_OPC) begin
            exp.data = {{32{inst[31]}}, inst[31:12], 12'h000};
        end else if (inst[6:0] == IMM_OPC) begin
            if (f3 == 3'd1) begin
                legal = (inst[31:26] == 6'd0);
            end else if (f3 == 3'd5) begin
                alt = (inst[31:26] == 6'b010000);
                legal = alt || (inst[31:26] == 6'd0);
            end
            exp.data = alu_ref(f3, alt, a, b);
        end else if (inst[6:0] == REG_OPC) begin
            b = shadow[inst[24:20]];
            alt = (inst[31:25] == 7'b0100000);
            legal = (inst[31:25] == 7'd0) || (alt && (f3 == 3'd0 || f3 == 3'd5));
            exp.data = alu_ref(f3, alt, a, b);
        end else begin
            legal = 1'b0;
        end
        exp.pc = next_pc;
        exp.inst = inst;
        exp.we = legal;
        exp.illegal = !legal;
        exp.rd = inst[11:7];
        if (legal && exp.rd != 5'd0) begin
            shadow[exp.rd] = exp.data;
        end
    endtask

    // Presents one instruction and returns the cycles it waited for ready.
    task automatic issue(input logic [31:0] inst, output int stalls);
        retire_t exp;
        @(negedge clk);
        inst_valid_i = 1'b1;
        pc_i = next_pc;
        inst_i = inst;
        stalls = 0;
        @(posedge clk);
        while (!inst_ready_o && stalls < LIMIT) begin
            stalls++;
            @(posedge clk);
        end
        if (!inst_ready_o) begin
            $display("Timeout: instruction at pc %h was never accepted", next_pc);
            error_count++;
        end else begin
            model_exec(inst, exp);
            exp_q.push_back(exp);
        end
        next_pc = next_pc + 64'd4;
    endtask

    task automatic drain();
        int cycles;
        @(negedge clk);
        inst_valid_i = 1'b0;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d instructions never retired", exp_q.size());
            error_count++;
            exp_q.delete();
        end
    endtask

    // Retire monitor; state sampled here is the value before the edge.
    always @(posedge clk) begin
        retire_t got;
        retire_t exp;
        got = {retire_pc_o, retire_inst_o, retire_we_o, retire_illegal_o,
               retire_rd_o, retire_data_o};
        if (!rst_n) begin
            if (hold_armed) begin
                check_equal(64'((got != held) || (retire_valid_o != held_valid)), 64'd0,
                            "retire outputs moved under wb_stall_i");
            end
            if (retire_valid_o && !wb_stall_i) begin
                if (exp_q.size() == 0) begin
                    $display("Unexpected retire of pc %h with nothing outstanding", retire_pc_o);
                    error_count++;
                end else begin
                    exp = exp_q.pop_front();
                    check_equal(got.pc, exp.pc, "retire pc");
                    check_equal(64'(got.inst), 64'(exp.inst),
                                $sformatf("retire inst of pc %h", exp.pc));
                    check_equal(64'({got.we, got.illegal, got.rd}),
                                64'({exp.we, exp.illegal, exp.rd}),
                                $sformatf("we, illegal, rd of pc %h", exp.pc));
                    if (!exp.illegal) begin
                        check_equal(got.data, exp.data, $sformatf("result of pc %h", exp.pc));
                    end
                    retire_count++;
                end
            end
            hold_armed = wb_stall_i;
            held = got;
            held_valid = retire_valid_o;
        end else begin
            hold_armed = 1'b0;
        end
    end

    // Writeback stall bursts.
    always @(negedge clk) begin
        if (stall_enable && stall_left > 0) begin
            wb_stall_i = 1'b1;
            stall_left--;
        end else if (stall_enable) begin
            stall_state = xorshift(stall_state);
            wb_stall_i = (stall_state[1:0] == 2'd0);
            stall_left = wb_stall_i ? int'(stall_state[3:2]) : 0;
        end else begin
            wb_stall_i = 1'b0;
            stall_left = 0;
        end
    end

    task automatic reset_test();
        @(negedge clk);
        check_equal(64'(inst_ready_o), 64'd1, "inst_ready_o after reset");
        check_equal(64'(retire_valid_o), 64'd0, "retire_valid_o after reset");
        check_equal(64'(retire_we_o), 64'd0, "retire_we_o after reset");
        check_equal(64'(retire_illegal_o), 64'd0, "retire_illegal_o after reset");
    endtask

    task automatic independent_test();
        int          stalls;
        logic [63:0] r;
        for (int k = 0; k < 5; k++) begin
            r = next_rand();
            issue(enc_i(3'd0, 1'b0, r[11:0], 5'(k + 1), 5'd0), stalls);
            check_equal(64'(stalls), 64'd0, "ADDI waited for ready");
        end
        for (int k = 0; k < 3; k++) begin
            r = next_rand();
            issue({r[19:0], 5'(k + 6), LUI_OPC}, stalls);
            check_equal(64'(stalls), 64'd0, "LUI waited for ready");
        end
        // All eight funct3 groups, then SUB and SRA.
        for (int k = 0; k < 10; k++) begin
            issue(enc_r((k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5), k >= 8, 5'(k + 10),
                        5'(k % 8 + 1), 5'((k + 3) % 8 + 1)), stalls);
            check_equal(64'(stalls), 64'd0, "register op waited for ready");
        end
        for (int k = 0; k < 9; k++) begin
            r = next_rand();
            issue(enc_i((k < 8) ? 3'(k) : 3'd5, k == 8, r[11:0], 5'(k + 20),
                        5'(k % 8 + 1)), stalls);
            check_equal(64'(stalls), 64'd0, "immediate op waited for ready");
        end
    endtask

    task automatic dependent_test();
        int          stalls;
        logic [63:0] r;
        logic [4:0]  prev;
        logic [4:0]  rd;
        logic [2:0]  f3;
        prev = 5'd1;
        for (int k = 0; k < 8; k++) begin
            r = next_rand();
            rd = k[0] ? 5'd12 : 5'd9;
            f3 = r[2:0];
            if (k[0]) begin
                issue(enc_i(f3, r[3] && f3 == 3'd5, r[23:12], rd, prev), stalls);
            end else begin
                issue(enc_r(f3, r[3] && (f3 == 3'd0 || f3 == 3'd5), rd, prev,
                            5'(r[6:4]) + 5'd1), stalls);
            end
            if (k > 0) begin
                check_equal(64'(stalls), 64'd1, "ready low cycles behind producer");
            end
            prev = rd;
        end
    endtask

    task automatic wb_stall_test();
        int          stalls;
        int          start;
        logic [63:0] r;
        logic [2:0]  f3;
        start = retire_count;
        stall_enable = 1'b1;
        for (int k = 0; k < 16; k++) begin
            r = next_rand();
            f3 = r[2:0];
            if (r[7]) begin
                issue(enc_r(f3, r[3] && (f3 == 3'd0 || f3 == 3'd5), 5'(r[11:8]) + 5'd1,
                            r[16:12], r[21:17]), stalls);
            end else begin
                issue(enc_i(f3, r[3] && f3 == 3'd5, r[33:22], 5'(r[11:8]) + 5'd1,
                            r[16:12]), stalls);
            end
        end
        drain();
        stall_enable = 1'b0;
        check_equal(64'(retire_count - start), 64'd16, "entries retired under wb_stall_i");
    endtask

    task automatic illegal_test();
        int          stalls;
        logic [63:0] r;
        r = next_rand();
        issue(enc_i(3'd0, 1'b0, r[11:0], 5'd13, 5'd0), stalls);
        // A load, a multiply and an SRAI with a bad funct6 that all target x13.
        issue({r[31:20], 5'd1, 3'd3, 5'd13, 7'b0000011}, stalls);
        issue({7'b0000001, 5'd2, 5'd1, 3'd0, 5'd13, REG_OPC}, stalls);
        issue({6'b100000, 6'd3, 5'd1, 3'd5, 5'd13, IMM_OPC}, stalls);
        issue(enc_i(3'd0, 1'b0, 12'h000, 5'd14, 5'd13), stalls);
    endtask

    task automatic x0_test();
        int          stalls;
        logic [63:0] r;
        r = next_rand();
        issue(enc_i(3'd0, 1'b0, r[11:0], 5'd0, 5'd1), stalls);
        issue(enc_r(3'd0, 1'b0, 5'd0, 5'd1, 5'd2), stalls);
        issue({r[31:12], 5'd0, LUI_OPC}, stalls);
        issue(enc_r(3'd0, 1'b0, 5'd15, 5'd0, 5'd0), stalls);
        issue(enc_i(3'd6, 1'b0, 12'h000, 5'd16, 5'd0), stalls);
    endtask

    initial begin
        rng_state = 64'd12680;
        stall_state = 64'd12680;
        next_pc = 64'h1000;
        stall_enable = 1'b0;
        stall_left = 0;
        hold_armed = 1'b0;
        error_count = 0;
        check_count = 0;
        retire_count = 0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        inst_valid_i = 1'b0;
        pc_i = '0;
        inst_i = '0;
        wb_stall_i = 1'b0;
        // Reset is active high on rst_n.
        rst_n = 1'b1;
        repeat (2) @(negedge clk);
        rst_n = 1'b0;
        reset_test();
        independent_test();
        drain();
        dependent_test();
        drain();
        wb_stall_test();
        illegal_test();
        drain();
        x0_test();
        drain();
        $display("Checks: %0d, retired: %0d, errors: %0d", check_count, retire_count,
                 error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
hdl/rv_isa_pkg.sv
hdl/pipe_pkg.sv
hdl/reg_file.sv
hdl/decode_unit.sv
hdl/hazard_ctrl.sv
hdl/pipe_reg.sv
hdl/alu_exec.sv
hdl/exec_pipe_top.sv
tb/exec_pipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the result line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f sim.f \
    --top-module exec_pipe_tb -o exec_pipe_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/exec_pipe_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q -x "TEST RESULT: PASS"; then
    exit 0
fi
exit 1
